/* common/tcb_pkg.sv */
// tcb bus definitions

package tcb_pkg;

    ////////////////////
    // bus widths
    ////////////////////

    // data width in bits
    localparam int DAT_W = 32;
    // bytes per data word
    localparam int BYT_N = DAT_W / 8;
    // byte address width
    localparam int ADR_W = 16;

    ////////////////////
    // address map
    ////////////////////

    // memory 0 starts at address zero
    // memory 1 occupies the upper half of the address space
    localparam logic [ADR_W-1:0] MEM1_BASE = 16'h8000;

    // cycles from request transfer to response at the subsystem boundary
    localparam int RSP_DLY = 2;

    ////////////////////
    // byte select
    ////////////////////

    // logarithmic size view
    typedef struct packed {
        // reserved, must be zero
        logic [1:0] rsv;
        // log2 of the number of bytes
        logic [1:0] siz;
    } tcb_log_t;

    // the same 4 bits seen either as a byte mask or as a log size
    typedef union packed {
        // byte enable mask, bit i enables data byte i
        logic [BYT_N-1:0] byt;
        tcb_log_t         log;
    } tcb_sel_u;

    ////////////////////
    // request and response
    ////////////////////

    typedef struct packed {
        // write enable
        logic             wen;
        // byte address
        logic [ADR_W-1:0] adr;
        // byte select, decoded per bus mode
        tcb_sel_u         sel;
        // write data
        logic [DAT_W-1:0] wdt;
    } tcb_req_t;

    typedef struct packed {
        // read data
        logic [DAT_W-1:0] rdt;
        // error flag
        logic             err;
    } tcb_rsp_t;

endpackage

/* rtl/tcb_decoder.sv */
// tcb address decoder

`timescale 1ns/1ps

module tcb_decoder #(
    parameter int MEM0_DEPTH = 64,
    parameter int MEM1_DEPTH = 32
)(
    input  logic               man,
    input  logic               rst_n,
    // upstream side
    input  logic               vld,
    input  tcb_pkg::tcb_req_t  req,
    output logic               rdy,
    output tcb_pkg::tcb_rsp_t  rsp,
    // memory 0
    output logic               mem0_vld,
    input  logic               mem0_rdy,
    input  tcb_pkg::tcb_rsp_t  mem0_rsp,
    // memory 1
    output logic               mem1_vld,
    input  logic               mem1_rdy,
    input  tcb_pkg::tcb_rsp_t  mem1_rsp
);

    // address relative to memory 1 base
    logic [tcb_pkg::ADR_W-1:0] mem1_off;
    // region hits for the current request
    logic                      hit0;
    logic                      hit1;
    // ready for unmapped requests, low through reset
    logic                      unm_rdy;
    // transfer on this edge
    logic                      trn;
    // selected target of the last transfer, one-hot {mem1, mem0}
    // all zero means unmapped
    logic [1:0]                tgt_q;

    ////////////////////
    // region decode
    ////////////////////

    assign mem1_off = req.adr - tcb_pkg::MEM1_BASE;

    // word index must also be inside the memory depth
    assign hit0 = (req.adr < tcb_pkg::MEM1_BASE)
                && (req.adr[tcb_pkg::ADR_W-1:2] < MEM0_DEPTH);
    assign hit1 = (req.adr >= tcb_pkg::MEM1_BASE)
                && (mem1_off[tcb_pkg::ADR_W-1:2] < MEM1_DEPTH);

    // only the selected memory sees vld, and only once it is ready
    assign mem0_vld = vld & hit0 & mem0_rdy;
    assign mem1_vld = vld & hit1 & mem1_rdy;

    // upstream ready comes from the addressed target
    always_comb begin
        if (hit0) begin
            rdy = mem0_rdy;
        end else if (hit1) begin
            rdy = mem1_rdy;
        end else begin
            rdy = unm_rdy;
        end
    end

    assign trn = vld & rdy;

    ////////////////////
    // target tracking
    ////////////////////

    always_ff @(posedge man) begin
        if (!rst_n) begin
            unm_rdy <= 1'b0;
            tgt_q   <= 2'b00;
        end else begin
            unm_rdy <= 1'b1;
            if (trn) begin
                tgt_q <= {hit1, hit0};
            end
        end
    end

    // response mux, no added delay
    always_comb begin
        case (tgt_q)
            2'b01: rsp = mem0_rsp;
            2'b10: rsp = mem1_rsp;
            default: begin
                // unmapped target answers with an error and zero data
                rsp.rdt = '0;
                rsp.err = 1'b1;
            end
        endcase
    end

    // at most one subordinate is addressed at a time
    assert property (@(posedge man) disable iff (!rst_n) !(mem0_vld && mem1_vld))
        else $error("decoder drove both memory valids");

endmodule

/* rtl/tcb_register_response.sv */
// tcb response register slice

`timescale 1ns/1ps

module tcb_register_response #(
    // 0 for logarithmic size, 1 for byte enable
    parameter int MOD = 1
)(
    input  logic              man,
    input  logic              rst_n,
    // toward the external manager
    input  logic              sub_vld,
    input  tcb_pkg::tcb_req_t sub_req,
    output logic              sub_rdy,
    output tcb_pkg::tcb_rsp_t sub_rsp,
    // toward the decoder
    output logic              man_vld,
    output tcb_pkg::tcb_req_t man_req,
    input  logic              man_rdy,
    input  tcb_pkg::tcb_rsp_t man_rsp
);

    logic                      trn;
    // transfer flag, write enable and select from the previous cycle
    logic                      trn_dly;
    logic                      wen_dly;
    tcb_pkg::tcb_sel_u         sel_dly;
    // byte enables derived from the delayed select
    logic [tcb_pkg::BYT_N-1:0] ben;
    // held response
    logic [tcb_pkg::DAT_W-1:0] rdt_q;
    logic                      err_q;

    if (MOD != 0 && MOD != 1) begin : g_bad_mod
        $error("tcb_register_response: MOD must be 0 or 1");
    end

    ////////////////////
    // request pass
    ////////////////////

    assign man_vld = sub_vld;
    assign man_req = sub_req;
    assign sub_rdy = man_rdy;

    assign trn = sub_vld & sub_rdy;

    always_ff @(posedge man) begin
        if (!rst_n) begin
            trn_dly <= 1'b0;
        end else begin
            trn_dly <= trn;
        end
    end

    // only sampled when trn_dly is set
    always_ff @(posedge man) begin
        if (trn) begin
            wen_dly <= sub_req.wen;
            sel_dly <= sub_req.sel;
        end
    end

    ////////////////////
    // response register
    ////////////////////

    always_comb begin
        for (int i = 0; i < tcb_pkg::BYT_N; i++) begin
            if (MOD == 1) begin
                ben[i] = sel_dly.byt[i];
            end else begin
                ben[i] = (i < (1 << sel_dly.log.siz));
            end
        end
    end

    // read bytes update only when enabled, writes keep the old data
    always_ff @(posedge man) begin
        if (!rst_n) begin
            rdt_q <= '0;
            err_q <= 1'b0;
        end else if (trn_dly) begin
            err_q <= man_rsp.err;
            for (int i = 0; i < tcb_pkg::BYT_N; i++) begin
                if (!wen_dly && ben[i]) begin
                    rdt_q[8*i +: 8] <= man_rsp.rdt[8*i +: 8];
                end
            end
        end
    end

    assign sub_rsp.rdt = rdt_q;
    assign sub_rsp.err = err_q;

    // downstream path must answer with a defined error one cycle before the slice output
    assert property (@(posedge man) disable iff (!rst_n)
        trn |-> ##(tcb_pkg::RSP_DLY-1) !$isunknown(man_rsp.err))
        else $error("tcb_register_response: unknown err after transfer");

endmodule

/* rtl/tcb_subsystem_top.sv */
// tcb subsystem top level

`timescale 1ns/1ps

module tcb_subsystem_top #(
    // 0 for logarithmic size, 1 for byte enable
    parameter int MOD        = 1,
    // memory sizes in words
    parameter int MEM0_DEPTH = 64,
    parameter int MEM1_DEPTH = 32
)(
    input  logic              man,
    input  logic              rst_n,
    input  logic              req_vld,
    input  tcb_pkg::tcb_req_t req,
    output logic              req_rdy,
    output tcb_pkg::tcb_rsp_t rsp
);

    // slice to decoder
    logic              dec_vld;
    tcb_pkg::tcb_req_t dec_req;
    logic              dec_rdy;
    tcb_pkg::tcb_rsp_t dec_rsp;

    // decoder to memories
    logic              mem0_vld;
    logic              mem0_rdy;
    tcb_pkg::tcb_rsp_t mem0_rsp;
    logic              mem1_vld;
    logic              mem1_rdy;
    tcb_pkg::tcb_rsp_t mem1_rsp;

    ////////////////////
    // result stage
    ////////////////////

    tcb_register_response #(
        .MOD (MOD)
    ) u_slice (
        .man     (man),
        .rst_n   (rst_n),
        .sub_vld (req_vld),
        .sub_req (req),
        .sub_rdy (req_rdy),
        .sub_rsp (rsp),
        .man_vld (dec_vld),
        .man_req (dec_req),
        .man_rdy (dec_rdy),
        .man_rsp (dec_rsp)
    );

    ////////////////////
    // decode stage
    ////////////////////

    tcb_decoder #(
        .MEM0_DEPTH (MEM0_DEPTH),
        .MEM1_DEPTH (MEM1_DEPTH)
    ) u_dec (
        .man      (man),
        .rst_n    (rst_n),
        .vld      (dec_vld),
        .req      (dec_req),
        .rdy      (dec_rdy),
        .rsp      (dec_rsp),
        .mem0_vld (mem0_vld),
        .mem0_rdy (mem0_rdy),
        .mem0_rsp (mem0_rsp),
        .mem1_vld (mem1_vld),
        .mem1_rdy (mem1_rdy),
        .mem1_rsp (mem1_rsp)
    );

    ////////////////////
    // execute stage
    ////////////////////

    // both memories see the same request, low address bits index them
    tcb_mem #(
        .MOD   (MOD),
        .DEPTH (MEM0_DEPTH)
    ) u_mem0 (
        .man   (man),
        .rst_n (rst_n),
        .vld   (mem0_vld),
        .req   (dec_req),
        .rdy   (mem0_rdy),
        .rsp   (mem0_rsp)
    );

    tcb_mem #(
        .MOD   (MOD),
        .DEPTH (MEM1_DEPTH)
    ) u_mem1 (
        .man   (man),
        .rst_n (rst_n),
        .vld   (mem1_vld),
        .req   (dec_req),
        .rdy   (mem1_rdy),
        .rsp   (mem1_rsp)
    );

endmodule

/* tb/tcb_subsystem_tb.sv */
// tcb subsystem testbench

`timescale 1ns/1ps

module tcb_subsystem_tb #(
    // 0 for logarithmic size, 1 for byte enable
    parameter int MOD = 1
);

    localparam int MEM0_DEPTH = 64;
    localparam int MEM1_DEPTH = 32;
    localparam int RST_CYC    = 10;
    // cycles a request may wait for req_rdy
    localparam int TIMEOUT    = 20;
    localparam int DLY        = tcb_pkg::RSP_DLY;
    // bytes per region in the reference model
    localparam int MDL_N      = 4 * ((MEM0_DEPTH > MEM1_DEPTH) ? MEM0_DEPTH : MEM1_DEPTH);

    logic              man;
    logic              rst_n;
    logic              req_vld;
    tcb_pkg::tcb_req_t req;
    logic              req_rdy;
    tcb_pkg::tcb_rsp_t rsp;

    logic [31:0]       lfsr;
    string             test_name;
    // reference memories, one byte array per region
    logic [7:0]        mdl [2][MDL_N];
    // read data held by the result stage
    logic [31:0]       hold_rdt;
    // transfers seen by the memories
    int                trn_cnt;
    // expected responses in flight, index is the age in cycles
    logic              pipe_vld [1:DLY];
    tcb_pkg::tcb_rsp_t pipe_exp [1:DLY];

    tcb_subsystem_top #(
        .MOD        (MOD),
        .MEM0_DEPTH (MEM0_DEPTH),
        .MEM1_DEPTH (MEM1_DEPTH)
    ) uut (
        .man     (man),
        .rst_n   (rst_n),
        .req_vld (req_vld),
        .req     (req),
        .req_rdy (req_rdy),
        .rsp     (rsp)
    );

    always #5 man = ~man;

    ////////////////////
    // stimulus helpers
    ////////////////////

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return val;
    endfunction

    // whole word in either bus mode
    function automatic tcb_pkg::tcb_sel_u full_sel();
        tcb_pkg::tcb_sel_u sel;
        if (MOD == 1) begin
            sel.byt = 4'hf;
        end else begin
            sel.log.rsv = 2'b00;
            sel.log.siz = 2'd2;
        end
        return sel;
    endfunction

    // word w counted over memory 0 then memory 1
    function automatic logic [15:0] word_adr(input int w);
        if (w < MEM0_DEPTH) begin
            return 16'(w * 4);
        end
        return tcb_pkg::MEM1_BASE + 16'((w - MEM0_DEPTH) * 4);
    endfunction

    // random word inside one of the memories
    function automatic logic [15:0] mapped_adr(input logic [1:0] lo);
        logic        rgn;
        logic [12:0] widx;
        rgn  = 1'(rand_bits(1));
        widx = 13'(rand_bits(13) % (rgn ? MEM1_DEPTH : MEM0_DEPTH));
        return {rgn, widx, lo};
    endfunction

    // word index past the end of a region
    function automatic logic [15:0] unmapped_adr();
        logic        rgn;
        int          dep;
        logic [12:0] widx;
        rgn  = 1'(rand_bits(1));
        dep  = rgn ? MEM1_DEPTH : MEM0_DEPTH;
        widx = 13'(dep + rand_bits(13) % (8192 - dep));
        return {rgn, widx, 2'b00};
    endfunction

    // returns on the falling edge after the transfer
    task automatic wait_accept();
        logic acc;
        int   waited;
        acc    = 1'b0;
        waited = 0;
        while (!acc && waited < TIMEOUT) begin
            @(posedge man);
            acc = req_rdy;
            @(negedge man);
            waited++;
        end
        if (!acc) begin
            $display("req_rdy never rose within %0d cycles in test %s", TIMEOUT, test_name);
            $display("Simulation FAILED");
            $fatal(1, "request timeout");
        end
    endtask

    task automatic send(input logic wen, input logic [15:0] adr,
                        input tcb_pkg::tcb_sel_u sel, input logic [31:0] wdt);
        req_vld = 1'b1;
        req.wen = wen;
        req.adr = adr;
        req.sel = sel;
        req.wdt = wdt;
        wait_accept();
    endtask

    task automatic idle(input int n);
        req_vld = 1'b0;
        repeat (n) @(negedge man);
    endtask

    // legal transfer with random direction, place and select
    task automatic random_xfer();
        tcb_pkg::tcb_sel_u sel;
        logic              wen;
        logic [1:0]        lo;
        wen = 1'(rand_bits(1));
        lo  = 2'(rand_bits(2));
        if (MOD == 1) begin
            // empty mask may come up, it answers with err
            sel.byt = 4'(rand_bits(4));
        end else begin
            sel.log.rsv = 2'b00;
            sel.log.siz = 2'(rand_bits(2) % 3);
            // offset aligned to the size
            if (sel.log.siz == 2'd1) lo[0] = 1'b0;
            if (sel.log.siz == 2'd2) lo = 2'b00;
        end
        send(wen, mapped_adr(lo), sel, rand_bits(32));
    endtask

    ////////////////////
    // reference model
    ////////////////////

    always @(posedge man) begin : model
        logic              rgn;
        logic              mapped;
        logic              serr;
        logic [3:0]        ben;
        int                widx;
        int                off;
        int                nb;
        tcb_pkg::tcb_rsp_t exp_rsp;
        // transfers that reach either memory, counted through reset too
        if ((uut.mem0_vld && uut.mem0_rdy) || (uut.mem1_vld && uut.mem1_rdy)) begin
            trn_cnt++;
        end
        if (!rst_n) begin
            hold_rdt = '0;
            for (int d = 1; d <= DLY; d++) begin
                pipe_vld[d] <= 1'b0;
            end
        end else begin
            for (int d = DLY; d > 1; d--) begin
                pipe_vld[d] <= pipe_vld[d-1];
                pipe_exp[d] <= pipe_exp[d-1];
            end
            pipe_vld[1] <= req_vld && req_rdy;
            if (req_vld && req_rdy) begin
                // bit 15 picks the region, bits 14:2 the word inside it
                rgn    = req.adr[15];
                widx   = req.adr[14:2];
                mapped = widx < (rgn ? MEM1_DEPTH : MEM0_DEPTH);
                if (MOD == 1) begin
                    ben  = req.sel.byt;
                    off  = 0;
                    serr = (req.sel.byt == 4'h0);
                end else begin
                    // 2**siz bytes placed from the addressed byte
                    nb   = 1 << req.sel.log.siz;
                    off  = req.adr[1:0];
                    serr = (req.sel.log.rsv != 2'b00) || (off % nb != 0);
                    for (int i = 0; i < 4; i++) begin
                        ben[i] = (i < nb);
                    end
                end
                exp_rsp.err = !mapped || serr;
                for (int i = 0; i < 4; i++) begin
                    if (ben[i] && req.wen && !exp_rsp.err) begin
                        mdl[rgn][4*widx + off + i] = req.wdt[8*i +: 8];
                    end else if (ben[i] && !req.wen && mapped) begin
                        hold_rdt[8*i +: 8] = mdl[rgn][4*widx + off + i];
                    end else if (ben[i] && !req.wen) begin
                        // unmapped reads return zero data
                        hold_rdt[8*i +: 8] = 8'h00;
                    end
                end
                exp_rsp.rdt = hold_rdt;
                pipe_exp[1] <= exp_rsp;
            end
        end
    end

    // every response is due RSP_DLY cycles after its transfer
    assert property (@(posedge man) disable iff (!rst_n)
        pipe_vld[DLY] |-> (rsp === pipe_exp[DLY]))
    else begin
        $display("mismatch %s: expected rdt %h err %b actual rdt %h err %b", test_name,
                 $sampled(pipe_exp[DLY].rdt), $sampled(pipe_exp[DLY].err),
                 $sampled(rsp.rdt), $sampled(rsp.err));
        $display("Simulation FAILED");
        $fatal(1, "response check failed");
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        tcb_pkg::tcb_sel_u sel;
        logic [15:0]       adr;
        logic [1:0]        lo;
        man       = 1'b0;
        rst_n     = 1'b0;
        req_vld   = 1'b0;
        req       = '0;
        lfsr      = 32'ha3fde03a;
        trn_cnt   = 0;
        test_name = "reset";

        // a write waits across reset release
        for (int c = 0; c < RST_CYC; c++) begin
            @(negedge man);
            assert (req_rdy === 1'b0 && rsp === '0) else begin
                $display("mismatch %s: expected req_rdy 0 rsp 0 actual req_rdy %b rsp %h",
                         test_name, req_rdy, rsp);
                $display("Simulation FAILED");
                $fatal(1, "reset state check failed");
            end
            if (c == 0) begin
                req_vld = 1'b1;
                req.wen = 1'b1;
                req.adr = 16'h0014;
                req.sel = full_sel();
                req.wdt = rand_bits(32);
            end
        end
        rst_n     = 1'b1;
        test_name = "stall";
        wait_accept();
        idle(DLY + 1);
        assert (trn_cnt == 1) else begin
            $display("mismatch %s: expected 1 memory transfer actual %0d", test_name, trn_cnt);
            $display("Simulation FAILED");
            $fatal(1, "stalled request count check failed");
        end
        send(1'b0, 16'h0014, full_sel(), 32'h0);
        idle(DLY + 1);

        // whole memory gets a known pattern
        test_name = "fill";
        for (int w = 0; w < MEM0_DEPTH + MEM1_DEPTH; w++) begin
            adr = word_adr(w);
            send(1'b1, adr, full_sel(), {adr ^ 16'hc3a5, adr});
        end

        // read right behind write, two in flight
        test_name = "write_read";
        for (int n = 0; n < 32; n++) begin
            adr = mapped_adr(2'b00);
            send(1'b1, adr, full_sel(), rand_bits(32));
            send(1'b0, adr, full_sel(), 32'h0);
        end

        test_name = "partial";
        repeat (200) random_xfer();

        test_name = "unmapped";
        for (int n = 0; n < 16; n++) begin
            adr = unmapped_adr();
            send(1'b1, adr, full_sel(), rand_bits(32));
            send(1'b0, adr, full_sel(), 32'h0);
        end

        test_name = "sel_err";
        for (int n = 0; n < 16; n++) begin
            adr = mapped_adr(2'b00);
            if (MOD == 1) begin
                sel.byt = 4'h0;
                send(1'b1, adr, sel, rand_bits(32));
            end else begin
                // misaligned word and half, then reserved bits set
                lo          = 2'(rand_bits(2)) | 2'b01;
                sel.log.rsv = 2'b00;
                sel.log.siz = 2'd2;
                send(1'b1, adr | lo, sel, rand_bits(32));
                sel.log.siz = 2'd1;
                send(1'b1, adr | lo, sel, rand_bits(32));
                sel.log.rsv = 2'(rand_bits(2)) | 2'b01;
                sel.log.siz = 2'd2;
                send(1'b1, adr, sel, rand_bits(32));
                // legal size at an aligned offset
                sel.log.rsv = 2'b00;
                sel.log.siz = 2'(n % 3);
                lo          = (sel.log.siz == 2'd0) ? 2'(n)
                            : ((sel.log.siz == 2'd1) ? 2'b10 : 2'b00);
                send(1'b1, adr | lo, sel, rand_bits(32));
            end
            send(1'b0, adr, full_sel(), 32'h0);
        end

        // nothing outside the model may have changed
        test_name = "sweep";
        for (int w = 0; w < MEM0_DEPTH + MEM1_DEPTH; w++) begin
            send(1'b0, word_adr(w), full_sel(), 32'h0);
        end
        idle(DLY + 1);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* tcb_mem/tcb_mem.sv */
// tcb memory subordinate

`timescale 1ns/1ps

module tcb_mem #(
    // 0 for logarithmic size, 1 for byte enable
    parameter int MOD   = 1,
    // size in words
    parameter int DEPTH = 64
)(
    input  logic              man,
    input  logic              rst_n,
    input  logic              vld,
    input  tcb_pkg::tcb_req_t req,
    output logic              rdy,
    output tcb_pkg::tcb_rsp_t rsp
);

    localparam int AW = $clog2(DEPTH);

    // word storage, byte lanes little endian
    logic [tcb_pkg::DAT_W-1:0] mem [DEPTH];

    // word index, upper address bits are dropped so the base does not matter
    logic [AW-1:0]               idx;
    // byte offset inside the word
    logic [1:0]                  off;
    // enables per data lane and per memory byte
    logic [tcb_pkg::BYT_N-1:0]   ben_lane;
    logic [tcb_pkg::BYT_N-1:0]   ben;
    // write data moved onto memory byte positions
    logic [tcb_pkg::DAT_W-1:0]   wdt_al;
    // select error for the current request
    logic                        sel_err;
    logic                        trn;

    ////////////////////
    // parameter checks
    ////////////////////

    if (MOD != 0 && MOD != 1) begin : g_bad_mod
        $error("tcb_mem: MOD must be 0 or 1");
    end
    if (DEPTH < 2 || DEPTH > 2**(tcb_pkg::ADR_W-3)) begin : g_bad_depth
        $error("tcb_mem: DEPTH out of range");
    end

    ////////////////////
    // select decode
    ////////////////////

    assign idx = req.adr[AW+1:2];

    if (MOD == 0) begin : g_log
        always_comb begin
            off = req.adr[1:0];
            // data sits on the low lanes, 2**siz of them
            for (int i = 0; i < tcb_pkg::BYT_N; i++) begin
                ben_lane[i] = (i < (1 << req.sel.log.siz));
            end
            // address must be aligned to the transfer size
            case (req.sel.log.siz)
                2'd0:    sel_err = 1'b0;
                2'd1:    sel_err = req.adr[0];
                2'd2:    sel_err = |req.adr[1:0];
                // wider than one data word
                default: sel_err = 1'b1;
            endcase
            if (req.sel.log.rsv != 2'b00) begin
                sel_err = 1'b1;
            end
        end
    end else begin : g_byt
        always_comb begin
            // lanes map straight onto memory bytes
            off      = 2'd0;
            ben_lane = req.sel.byt;
            // empty mask is an error
            sel_err  = (req.sel.byt == '0);
        end
    end

    assign ben    = ben_lane << off;
    assign wdt_al = req.wdt << (8 * off);

    assign trn = vld & rdy;

    ////////////////////
    // storage and response
    ////////////////////

    // ready one cycle after reset release
    always_ff @(posedge man) begin
        if (!rst_n) begin
            rdy <= 1'b0;
        end else begin
            rdy <= 1'b1;
        end
    end

    // byte writes, dropped on error
    always_ff @(posedge man) begin
        if (trn && req.wen && !sel_err) begin
            for (int i = 0; i < tcb_pkg::BYT_N; i++) begin
                if (ben[i]) begin
                    mem[idx][8*i +: 8] <= wdt_al[8*i +: 8];
                end
            end
        end
    end

    // read word realigned to lane 0, valid in the next cycle
    always_ff @(posedge man) begin
        if (trn) begin
            rsp.rdt <= mem[idx] >> (8 * off);
            rsp.err <= sel_err;
        end
    end

    // the decoder must hold off until this memory is ready
    assert property (@(posedge man) disable iff (!rst_n) !(vld && !rdy))
        else $error("tcb_mem: vld asserted while not ready");

endmodule

/* tcb_subsystem_top.f */
common/tcb_pkg.sv
rtl/tcb_register_response.sv
rtl/tcb_decoder.sv
tcb_mem/tcb_mem.sv
rtl/tcb_subsystem_top.sv
tb/tcb_subsystem_tb.sv
